//--- dv/clk_monitor_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock monitor assertions
// word write timing against the byte strobe, count update timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clk_monitor_sva
    import clk_freq_pkg::*;
#(
    parameter int NUM_CHAN = 36
) (
    input  wire                  clk_200,
    input  wire                  reset,
    input  byte_req_t            req_i,
    input  word_wr_t             word_wr_i,
    input  logic                 gate_tick_i,
    input  freq_t [NUM_CHAN-1:0] freqs_i
);

    // failure count, polled by the testbench every cycle
    int unsigned fail_cnt = 0;

    // every byte strobe becomes a word write on the next edge
    strobe_to_write: assert property (@(posedge clk_200) disable iff (reset)
        req_i.wr |=> word_wr_i.wr)
    else begin
        $error("byte strobe not followed by a word write one cycle later");
        fail_cnt++;
    end

    // no word write out of nowhere
    write_needs_strobe: assert property (@(posedge clk_200) disable iff (reset)
        $rose(word_wr_i.wr) |-> $past(req_i.wr))
    else begin
        $error("word write rose without a byte strobe the cycle before");
        fail_cnt++;
    end

    // counts move only on the latch edge after a tick
    count_on_tick: assert property (@(posedge clk_200) disable iff (reset)
        !$stable(freqs_i) |-> $past(gate_tick_i))
    else begin
        $error("channel count changed outside a gate tick");
        fail_cnt++;
    end

endmodule

bind clk_monitor_top clk_monitor_sva #(
    .NUM_CHAN (NUM_CHAN)
) clk_monitor_sva_inst (
    .clk_200     (clk_200),
    .reset       (reset),
    .req_i       (req_i),
    .word_wr_i   (word_wr),
    .gate_tick_i (freq_counter_bank_inst.gate_tick),
    .freqs_i     (freqs)
);

`default_nettype wire

//--- dv/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset generator
// free running clk_200 and an active high reset held for a few cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_200_o,
    output logic reset_o
);

    initial begin
        clk_200_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_200_o = ~clk_200_o;
    end

    // release just after an edge, like the other inputs
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_200_o);
        #2 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_clk_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock monitor testbench
// eight free running clocks, byte bus reads and writes, checks on the
// scratch words, the partial write path and the measured counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clk_monitor
    import clk_freq_pkg::*;
();

    localparam int NUM_CHAN    = 8;
    localparam int GATE_CYCLES = 2000;
    localparam int DRIVE_DLY   = 2;
    localparam int SAMPLE_DLY  = 10;
    // window length in ns, 2000 cycles of 40 ns
    localparam int WINDOW_NS   = GATE_CYCLES * 40;
    localparam int UNMAPPED    = 63;
    localparam int unsigned RNG_SEED = 32'h7abd_ffb8;
    localparam int PERIODS [NUM_CHAN] = '{100, 130, 170, 210, 260, 333, 500, 1000};

    wire                 clk_200;
    wire                 reset;
    logic [NUM_CHAN-1:0] meas_clk;
    byte_req_t           req;
    byte_t               rdata;
    // model of the bridge assembly longword
    byte_t               shadow [4];

    tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) tb_clk_gen_inst (
        .clk_200_o (clk_200),
        .reset_o   (reset)
    );

    // measured clocks, unrelated to clk_200
    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_meas
        logic clk_q = 1'b0;
        always #(PERIODS[c] / 2.0) clk_q = ~clk_q;
        assign meas_clk[c] = clk_q;
    end

    clk_monitor_top #(
        .NUM_CHAN    (NUM_CHAN),
        .GATE_CYCLES (GATE_CYCLES)
    ) clk_monitor_top_inst (
        .clk_200    (clk_200),
        .reset      (reset),
        .meas_clk_i (meas_clk),
        .req_i      (req),
        .rdata_o    (rdata)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // step to the drive point of the next cycle
    // bound assertions fire on the edge, so look for failures here
    task automatic next_cycle();
        @(posedge clk_200);
        #DRIVE_DLY;
        if (clk_monitor_top_inst.clk_monitor_sva_inst.fail_cnt != 0) begin
            fail_run("a bound assertion in clk_monitor_sva failed");
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            next_cycle();
            cycles++;
            if (cycles > 64) fail_run("timeout: reset was never released");
        end
    endtask

    // one cycle strobe, map takes the word one edge later
    task automatic write_byte(input int word, input int lane, input byte_t data);
        next_cycle();
        req.wr    = 1'b1;
        req.addr  = byte_addr_t'(word * 4 + lane);
        req.wdata = data;
        shadow[lane] = data;
        next_cycle();
        req.wr = 1'b0;
    endtask

    // reads are combinational, sample mid cycle
    task automatic read_byte(input int word, input int lane, output byte_t data);
        next_cycle();
        req.addr = byte_addr_t'(word * 4 + lane);
        #SAMPLE_DLY;
        data = rdata;
    endtask

    task automatic read_word(input int word, output freq_t data);
        byte_t b;
        data = '0;
        for (int lane = 0; lane < 4; lane++) begin
            read_byte(word, lane, b);
            data[lane*8 +: 8] = b;
        end
    endtask

    task automatic check_word(input int word, input freq_t exp);
        byte_t got;
        for (int lane = 0; lane < 4; lane++) begin
            read_byte(word, lane, got);
            assert (got == exp[lane*8 +: 8]) else
                fail_run($sformatf(
                    "** Error at %0t: rdata_o = 0x%02h, expected 0x%02h (word %0d lane %0d)",
                    $time, got, exp[lane*8 +: 8], word, lane));
        end
    endtask

    // count within one edge of WINDOW_NS / period
    task automatic check_count(input int ch);
        freq_t cnt;
        int    p;
        p = PERIODS[ch];
        read_word(STATUS_BASE + ch, cnt);
        assert (int'(cnt) * p >= WINDOW_NS - p && int'(cnt) * p <= WINDOW_NS + p) else
            fail_run($sformatf("** Error at %0t: freq[%0d] = %0d, expected %0d +/- 1",
                               $time, ch, cnt, WINDOW_NS / p));
    endtask

    task automatic wait_gate();
        int cycles;
        cycles = 0;
        while (clk_monitor_top_inst.freq_counter_bank_inst.gate_tick !== 1'b1) begin
            next_cycle();
            cycles++;
            if (cycles > GATE_CYCLES + 10) fail_run("timeout: no gate tick within one window");
        end
        // counts latch on the edge after the tick
        next_cycle();
    endtask

    initial begin
        freq_t word0;
        req    = '0;
        shadow = '{default: 8'h00};
        void'($urandom(RNG_SEED));
        wait_reset();

        // reset state, scratch and status words all zero
        for (int w = 0; w < STATUS_BASE + NUM_CHAN; w++) begin
            check_word(w, '0);
        end

        // scratch round trip through all four lanes of word 0
        for (int lane = 0; lane < 4; lane++) begin
            write_byte(0, lane, byte_t'($urandom()));
        end
        word0 = {shadow[3], shadow[2], shadow[1], shadow[0]};
        check_word(0, word0);
        check_word(1, '0);

        // lane 2 only, word 1 takes the whole longword
        write_byte(1, 2, byte_t'($urandom()));
        check_word(1, {shadow[3], shadow[2], shadow[1], shadow[0]});
        check_word(0, word0);

        // second window is clean of reset effects
        wait_gate();
        wait_gate();
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            check_count(ch);
        end

        // status and unmapped words drop writes
        write_byte(STATUS_BASE, 0, 8'h5a);
        write_byte(STATUS_BASE, 3, 8'hff);
        write_byte(UNMAPPED, 1, 8'hc3);
        check_count(0);
        check_word(UNMAPPED, '0);
        check_word(STATUS_BASE + NUM_CHAN, '0);
        // scratch word 0 untouched by those writes
        check_word(0, word0);

        if (clk_monitor_top_inst.clk_monitor_sva_inst.fail_cnt == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run("a bound assertion in clk_monitor_sva failed");
        end
    end

endmodule

`default_nettype wire

//--- hdl/byte_lane_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte lane bridge
// assembles bus bytes into a longword, issues the word write one
// cycle after the byte strobe, and picks the read lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module byte_lane_bridge
    import clk_freq_pkg::*;
(
    input  wire        clk_200,
    input  wire        reset,
    input  byte_req_t  req_i,
    input  freq_t      word_rdata_i,
    output word_addr_t rd_addr_o,
    output word_wr_t   word_wr_o,
    output byte_t      rdata_o
);

    logic [1:0] lane;
    // assembly longword, shared by all word addresses
    freq_t      longword_q;
    logic       wr_q;
    word_addr_t wr_addr_q;

    assign lane      = req_i.addr[1:0];
    assign rd_addr_o = req_i.addr[7:2];

    // byte demux into the longword
    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            longword_q <= '0;
        end else if (req_i.wr) begin
            longword_q[lane*8 +: 8] <= req_i.wdata;
        end
    end

    // strobe delayed by one, so the word write sees the new byte
    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= req_i.wr;
        end
    end

    // word address travels with the delayed strobe
    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            wr_addr_q <= '0;
        end else if (req_i.wr) begin
            wr_addr_q <= req_i.addr[7:2];
        end
    end

    assign word_wr_o.wr   = wr_q;
    assign word_wr_o.addr = wr_addr_q;
    assign word_wr_o.data = longword_q;

    // read lane mux
    always_comb begin
        case (lane)
            2'd0:    rdata_o = word_rdata_i[7:0];
            2'd1:    rdata_o = word_rdata_i[15:8];
            2'd2:    rdata_o = word_rdata_i[23:16];
            default: rdata_o = word_rdata_i[31:24];
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/clk_freq_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock monitor package
// shared widths, byte and word bus structs, register map layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package clk_freq_pkg;

    // frequency count or scratch word
    typedef logic [31:0] freq_t;
    // one byte on the external bus
    typedef logic [7:0]  byte_t;
    // bits 7..2 pick the word, bits 1..0 the lane
    typedef logic [7:0]  byte_addr_t;
    typedef logic [5:0]  word_addr_t;

    // external write / address request
    typedef struct packed {
        logic       wr;
        byte_addr_t addr;
        byte_t      wdata;
    } byte_req_t;

    // full word write, bridge to map
    typedef struct packed {
        logic       wr;
        word_addr_t addr;
        freq_t      data;
    } word_wr_t;

    // read/write scratch words at the bottom of the map
    localparam int NUM_RW      = 2;
    // first channel count sits right after the scratch words
    localparam int STATUS_BASE = NUM_RW;

endpackage

`default_nettype wire

//--- hdl/clk_monitor_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock monitor top level
// counter bank, register map and byte bridge behind one byte-wide bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "clk_freq_defs.svh"

module clk_monitor_top
    import clk_freq_pkg::*;
#(
    parameter int NUM_CHAN    = `CLK_MON_NUM_CHAN,
    parameter int GATE_CYCLES = `CLK_MON_GATE_CYCLES
) (
    input  wire                 clk_200,
    input  wire                 reset,
    input  logic [NUM_CHAN-1:0] meas_clk_i,
    input  byte_req_t           req_i,
    output byte_t               rdata_o
);

    freq_t [NUM_CHAN-1:0] freqs;
    word_wr_t             word_wr;
    word_addr_t           rd_addr;
    freq_t                word_rdata;

    // measured clocks in, one count per channel out
    freq_counter_bank #(
        .NUM_CHAN    (NUM_CHAN),
        .GATE_CYCLES (GATE_CYCLES)
    ) freq_counter_bank_inst (
        .clk_200    (clk_200),
        .reset      (reset),
        .meas_clk_i (meas_clk_i),
        .freqs_o    (freqs)
    );

    reg_map #(
        .NUM_CHAN (NUM_CHAN)
    ) reg_map_inst (
        .clk_200   (clk_200),
        .reset     (reset),
        .word_wr_i (word_wr),
        .rd_addr_i (rd_addr),
        .freqs_i   (freqs),
        .rdata_o   (word_rdata)
    );

    // bus side, stands where the i2c slave would be
    byte_lane_bridge byte_lane_bridge_inst (
        .clk_200      (clk_200),
        .reset        (reset),
        .req_i        (req_i),
        .word_rdata_i (word_rdata),
        .rd_addr_o    (rd_addr),
        .word_wr_o    (word_wr),
        .rdata_o      (rdata_o)
    );

endmodule

`default_nettype wire

//--- hdl/freq_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single channel frequency counter
// syncs the measured clock into clk_200, counts its rising edges and
// latches the count on every gate tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module freq_counter
    import clk_freq_pkg::*;
(
    input  wire   clk_200,
    input  wire   reset,
    input  logic  meas_clk_i,
    input  logic  gate_tick_i,
    output freq_t freq_o
);

    // three flop synchronizer, bit 2 is the safe one
    logic [2:0] sync_q;
    // previous synced level for edge detect
    logic       meas_prev_q;
    logic       rise;
    freq_t      edge_cnt_q;

    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            sync_q      <= '0;
            meas_prev_q <= 1'b0;
        end else begin
            sync_q      <= {sync_q[1:0], meas_clk_i};
            meas_prev_q <= sync_q[2];
        end
    end

    // low to high on the synced clock
    assign rise = sync_q[2] & ~meas_prev_q;

    // edge counter and result latch
    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            edge_cnt_q <= '0;
            freq_o     <= '0;
        end else if (gate_tick_i) begin
            // an edge on the tick cycle still belongs to the closing window
            freq_o     <= edge_cnt_q + freq_t'(rise);
            edge_cnt_q <= '0;
        end else begin
            edge_cnt_q <= edge_cnt_q + freq_t'(rise);
        end
    end

endmodule

`default_nettype wire

//--- hdl/freq_counter_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frequency counter bank
// one gate timer shared by an array of channel counters, so every
// count refers to the same measurement window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module freq_counter_bank
    import clk_freq_pkg::*;
#(
    parameter int NUM_CHAN    = 36,
    parameter int GATE_CYCLES = 200_000_000
) (
    input  wire                   clk_200,
    input  wire                   reset,
    input  logic [NUM_CHAN-1:0]   meas_clk_i,
    output freq_t [NUM_CHAN-1:0]  freqs_o
);

    // wide enough to hold GATE_CYCLES-1
    localparam int TIMER_W = (GATE_CYCLES > 1) ? $clog2(GATE_CYCLES) : 1;
    typedef logic [TIMER_W-1:0] gate_cnt_t;

    gate_cnt_t gate_cnt_q;
    logic      gate_tick;

    // gate timer, 0 .. GATE_CYCLES-1 then wrap
    // tick is registered, one cycle wide
    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            gate_cnt_q <= '0;
            gate_tick  <= 1'b0;
        end else if (gate_cnt_q == gate_cnt_t'(GATE_CYCLES - 1)) begin
            gate_cnt_q <= '0;
            gate_tick  <= 1'b1;
        end else begin
            gate_cnt_q <= gate_cnt_q + gate_cnt_t'(1);
            gate_tick  <= 1'b0;
        end
    end

    // one counter per measured clock, all on the same tick
    for (genvar ch = 0; ch < NUM_CHAN; ch++) begin : g_chan
        freq_counter freq_counter_inst (
            .clk_200     (clk_200),
            .reset       (reset),
            .meas_clk_i  (meas_clk_i[ch]),
            .gate_tick_i (gate_tick),
            .freq_o      (freqs_o[ch])
        );
    end

endmodule

`default_nettype wire

//--- hdl/reg_map.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map
// read/write scratch words followed by one read-only count word per
// channel, with a combinational word read mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module reg_map
    import clk_freq_pkg::*;
#(
    parameter int NUM_CHAN = 36
) (
    input  wire                   clk_200,
    input  wire                   reset,
    input  word_wr_t              word_wr_i,
    input  word_addr_t            rd_addr_i,
    input  freq_t [NUM_CHAN-1:0]  freqs_i,
    output freq_t                 rdata_o
);

    // scratch words, addresses 0 .. NUM_RW-1
    freq_t scratch_q [NUM_RW];

    // only scratch addresses take writes
    // status and unmapped words drop them
    always_ff @(posedge clk_200 or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_RW; i++) begin
                scratch_q[i] <= '0;
            end
        end else if (word_wr_i.wr) begin
            for (int i = 0; i < NUM_RW; i++) begin
                if (word_wr_i.addr == word_addr_t'(i)) begin
                    scratch_q[i] <= word_wr_i.data;
                end
            end
        end
    end

    // word read mux
    // zero beyond the last channel
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NUM_RW; i++) begin
            if (rd_addr_i == word_addr_t'(i)) begin
                rdata_o = scratch_q[i];
            end
        end
        // channel i lives at STATUS_BASE + i
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (rd_addr_i == word_addr_t'(STATUS_BASE + i)) begin
                rdata_o = freqs_i[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- include/clk_freq_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock monitor defaults
// channel count and gate length used as top level parameter defaults
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CLK_FREQ_DEFS_SVH
`define CLK_FREQ_DEFS_SVH

// number of measured clocks, 62 at most
`define CLK_MON_NUM_CHAN 36
// one second of clk_200, so counts come out in Hz
`define CLK_MON_GATE_CYCLES 200_000_000

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the clock monitor testbench with Verilator
# pass or fail comes from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_clk_monitor -o tb_clk_monitor \
    > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_clk_monitor > sim.log 2>&1

grep -qx "Test passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim.f
+incdir+include
hdl/clk_freq_pkg.sv
hdl/freq_counter.sv
hdl/freq_counter_bank.sv
hdl/reg_map.sv
hdl/byte_lane_bridge.sv
hdl/clk_monitor_top.sv
dv/tb_clk_gen.sv
dv/clk_monitor_sva.sv
dv/tb_clk_monitor.sv
